// ==== design/core.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module core (
    input  wire              clk,
    input  wire              rst_n,
    output wire              inst_start,
    output wire [`XLEN-1:0]  inst_addr,
    input  wire              inst_ready,
    input  wire [`XLEN-1:0]  inst_data,
    input  wire              inst_valid,
    output wire              d_start,
    output wire              d_write,
    output wire [`XLEN-1:0]  d_addr,
    output wire [`XLEN-1:0]  d_wdata,
    input  wire              d_ready,
    input  wire [`XLEN-1:0]  d_rdata,
    input  wire              d_rdata_valid,
    output wire              exit,
    output wire [`XLEN-1:0]  gp
);

    logic                         f_valid;
    logic [`XLEN-1:0]             f_pc;
    logic [`XLEN-1:0]             f_insn;
    logic                         stall;
    logic                         mem_busy;
    logic                         redirect;
    logic [`XLEN-1:0]             redirect_pc;
    logic                         br_taken;
    logic [`XLEN-1:0]             br_target;
    logic                         rf_we;
    logic [$clog2(`NUM_REGS)-1:0] rf_waddr;
    logic [`XLEN-1:0]             rf_wdata;

    pipe_if dx_if ();
    pipe_if xm_if ();

    fetch_stage u_fetch (.clk, .rst_n, .stall, .redirect, .redirect_pc,
        .inst_start, .inst_addr, .inst_ready, .inst_data, .inst_valid,
        .f_valid, .f_pc, .f_insn);

    // decode also watches the xm slot for hazards
    decode_stage u_decode (.clk, .rst_n, .f_valid, .f_pc, .f_insn,
        .redirect, .mem_busy, .rf_we, .rf_waddr, .rf_wdata, .stall,
        .dx(dx_if.src), .xm(xm_if.snk), .gp);

    execute_stage u_execute (.clk, .rst_n, .redirect, .mem_busy,
        .dx(dx_if.snk), .xm(xm_if.src), .br_taken, .br_target);

    mem_wb_stage u_mem_wb (.clk, .rst_n, .xm(xm_if.snk), .br_taken, .br_target,
        .d_start, .d_write, .d_addr, .d_wdata, .d_ready, .d_rdata, .d_rdata_valid,
        .mem_busy, .redirect, .redirect_pc, .rf_we, .rf_waddr, .rf_wdata, .exit);

endmodule

`default_nettype wire

// ==== design/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000

// ecall, the program ends when it reaches mem/wb
`define INSN_ECALL 32'h0000_0073

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait_data
    } fetch_state_e;

    // decoded controls travelling with each instruction
    typedef struct packed {
        alu_op_e alu_op;
        wb_sel_e wb_sel;
        logic    rf_wen;
        logic    mem_ren;
        logic    mem_wen;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    is_ecall;
        logic    use_imm;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module decode_stage (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           f_valid,
    input  wire [`XLEN-1:0]               f_pc,
    input  wire [`XLEN-1:0]               f_insn,
    input  wire                           redirect,
    input  wire                           mem_busy,
    input  wire                           rf_we,
    input  wire [$clog2(`NUM_REGS)-1:0]   rf_waddr,
    input  wire [`XLEN-1:0]               rf_wdata,
    output logic                          stall,
    pipe_if.src                           dx,
    pipe_if.snk                           xm,
    output logic [`XLEN-1:0]              gp
);

    localparam int RW = $clog2(`NUM_REGS);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [RW-1:0]    rd;
    logic [RW-1:0]    rs1;
    logic [RW-1:0]    rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    core_pkg::ctrl_t  ctrl;
    logic             legal;
    logic             use_rs1;
    logic             use_rs2;
    logic             hazard;

    // x0 reads zero, a same-cycle write is seen at once
    function automatic logic [`XLEN-1:0] rf_read(input logic [RW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (rf_we && rf_waddr == addr) begin
            return rf_wdata;
        end
        return regs[addr];
    endfunction

    function automatic logic slot_writes(input logic v, input logic wen,
                                         input logic [RW-1:0] slot_rd,
                                         input logic [RW-1:0] src);
        return v && wen && src != '0 && slot_rd == src;
    endfunction

    assign opcode = f_insn[6:0];
    assign rd     = f_insn[11:7];
    assign funct3 = f_insn[14:12];
    assign rs1    = f_insn[19:15];
    assign rs2    = f_insn[24:20];
    assign funct7 = f_insn[31:25];

    always_comb begin
        rs1_val = rf_read(rs1);
        rs2_val = rf_read(rs2);
    end

    // ****************************************
    // control decode
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = core_pkg::alu_add;
        ctrl.wb_sel = core_pkg::wb_alu;
        imm         = {{20{f_insn[31]}}, f_insn[31:20]};
        legal       = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b0;
        case (opcode)
            7'b0110011: begin
                ctrl.rf_wen = 1'b1;
                use_rs2     = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = core_pkg::alu_add;
                    10'b0100000_000: ctrl.alu_op = core_pkg::alu_sub;
                    10'b0000000_111: ctrl.alu_op = core_pkg::alu_and;
                    10'b0000000_110: ctrl.alu_op = core_pkg::alu_or;
                    10'b0000000_100: ctrl.alu_op = core_pkg::alu_xor;
                    default:         legal = 1'b0;
                endcase
            end
            7'b0010011: begin
                legal        = (funct3 == 3'b000);
                ctrl.rf_wen  = 1'b1;
                ctrl.use_imm = 1'b1;
            end
            7'b0110111: begin
                ctrl.alu_op  = core_pkg::alu_pass_b;
                ctrl.rf_wen  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = {f_insn[31:12], 12'b0};
                use_rs1      = 1'b0;
            end
            7'b0000011: begin
                legal        = (funct3 == 3'b010);
                ctrl.wb_sel  = core_pkg::wb_mem;
                ctrl.rf_wen  = 1'b1;
                ctrl.mem_ren = 1'b1;
                ctrl.use_imm = 1'b1;
            end
            7'b0100011: begin
                legal        = (funct3 == 3'b010);
                ctrl.mem_wen = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = {{20{f_insn[31]}}, f_insn[31:25], f_insn[11:7]};
                use_rs2      = 1'b1;
            end
            7'b1100011: begin
                legal          = (funct3[2:1] == 2'b00);
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm            = {{19{f_insn[31]}}, f_insn[31], f_insn[7],
                                  f_insn[30:25], f_insn[11:8], 1'b0};
                use_rs2        = 1'b1;
            end
            7'b1101111: begin
                ctrl.wb_sel = core_pkg::wb_pc_plus4;
                ctrl.rf_wen = 1'b1;
                ctrl.is_jal = 1'b1;
                imm         = {{11{f_insn[31]}}, f_insn[31], f_insn[19:12],
                               f_insn[20], f_insn[30:21], 1'b0};
                use_rs1     = 1'b0;
            end
            7'b1110011: begin
                legal         = (f_insn == `INSN_ECALL);
                ctrl.is_ecall = 1'b1;
                use_rs1       = 1'b0;
            end
            default: legal = 1'b0;
        endcase
    end

    // RAW check against the two younger-than-writeback slots
    assign hazard = f_valid &&
        ((use_rs1 && (slot_writes(dx.valid, dx.ctrl.rf_wen, dx.rd, rs1) ||
                      slot_writes(xm.valid, xm.ctrl.rf_wen, xm.rd, rs1))) ||
         (use_rs2 && (slot_writes(dx.valid, dx.ctrl.rf_wen, dx.rd, rs2) ||
                      slot_writes(xm.valid, xm.ctrl.rf_wen, xm.rd, rs2))));

    assign stall = hazard || mem_busy;
    assign gp    = regs[3];

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // ****************************************
    // dx slot, bubble on hazard or unknown encoding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else if (redirect) begin
            dx.valid <= 1'b0;
        end else if (!mem_busy) begin
            dx.valid <= f_valid && !hazard && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            dx.pc       <= f_pc;
            dx.ctrl     <= ctrl;
            dx.op_a     <= rs1_val;
            dx.op_b     <= rs2_val;
            dx.rs2_data <= rs2_val;
            dx.imm      <= imm;
            dx.rd       <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module execute_stage (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              redirect,
    input  wire              mem_busy,
    pipe_if.snk              dx,
    pipe_if.src              xm,
    output logic             br_taken,
    output logic [`XLEN-1:0] br_target
);

    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;
    logic             take;

    always_comb begin
        alu_b = dx.ctrl.use_imm ? dx.imm : dx.op_b;
        case (dx.ctrl.alu_op)
            core_pkg::alu_add:    alu_y = dx.op_a + alu_b;
            core_pkg::alu_sub:    alu_y = dx.op_a - alu_b;
            core_pkg::alu_and:    alu_y = dx.op_a & alu_b;
            core_pkg::alu_or:     alu_y = dx.op_a | alu_b;
            core_pkg::alu_xor:    alu_y = dx.op_a ^ alu_b;
            core_pkg::alu_pass_b: alu_y = alu_b;
            default:              alu_y = dx.op_a + alu_b;
        endcase
    end

    // beq when equal, bne when not
    assign take = dx.ctrl.is_jal ||
                  (dx.ctrl.is_branch && ((dx.op_a == dx.op_b) != dx.ctrl.branch_ne));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xm.valid <= 1'b0;
            br_taken <= 1'b0;
        end else if (redirect) begin
            xm.valid <= 1'b0;
            br_taken <= 1'b0;
        end else if (!mem_busy) begin
            xm.valid <= dx.valid;
            br_taken <= dx.valid && take;
        end
    end

    // op_a carries the alu result onward (load/store address too)
    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            xm.pc       <= dx.pc;
            xm.ctrl     <= dx.ctrl;
            xm.op_a     <= alu_y;
            xm.op_b     <= dx.op_b;
            xm.rs2_data <= dx.rs2_data;
            xm.imm      <= dx.imm;
            xm.rd       <= dx.rd;
            br_target   <= dx.pc + dx.imm;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module fetch_stage (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              stall,
    input  wire              redirect,
    input  wire [`XLEN-1:0]  redirect_pc,
    output logic             inst_start,
    output logic [`XLEN-1:0] inst_addr,
    input  wire              inst_ready,
    input  wire [`XLEN-1:0]  inst_data,
    input  wire              inst_valid,
    output logic             f_valid,
    output logic [`XLEN-1:0] f_pc,
    output logic [`XLEN-1:0] f_insn
);

    core_pkg::fetch_state_e state;
    logic [`XLEN-1:0]       pc;
    // reply of the outstanding request belongs to a flushed path
    logic                   drop;

    assign inst_start = (state == core_pkg::fetch_request);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= core_pkg::fetch_idle;
            pc        <= `RESET_PC;
            inst_addr <= `RESET_PC;
            drop      <= 1'b0;
            f_valid   <= 1'b0;
        end else begin
            // decode takes the word whenever it is not stalled
            if (redirect || !stall) begin
                f_valid <= 1'b0;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end
            case (state)
                core_pkg::fetch_idle: begin
                    if (!redirect && !stall) begin
                        state     <= core_pkg::fetch_request;
                        inst_addr <= pc;
                        pc        <= pc + `XLEN'(4);
                    end
                end
                core_pkg::fetch_request: begin
                    // request stays up until accepted, even on redirect
                    if (redirect) begin
                        drop <= 1'b1;
                    end
                    if (inst_ready) begin
                        state <= core_pkg::fetch_wait_data;
                    end
                end
                core_pkg::fetch_wait_data: begin
                    if (inst_valid) begin
                        state <= core_pkg::fetch_idle;
                        drop  <= 1'b0;
                        if (!drop && !redirect) begin
                            f_valid <= 1'b1;
                        end
                    end else if (redirect) begin
                        drop <= 1'b1;
                    end
                end
                default: state <= core_pkg::fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::fetch_wait_data && inst_valid) begin
            f_pc   <= inst_addr;
            f_insn <= inst_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module mem_wb_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    pipe_if.snk                          xm,
    input  wire                          br_taken,
    input  wire [`XLEN-1:0]              br_target,
    output logic                         d_start,
    output logic                         d_write,
    output logic [`XLEN-1:0]             d_addr,
    output logic [`XLEN-1:0]             d_wdata,
    input  wire                          d_ready,
    input  wire [`XLEN-1:0]              d_rdata,
    input  wire                          d_rdata_valid,
    output logic                         mem_busy,
    output logic                         redirect,
    output logic [`XLEN-1:0]             redirect_pc,
    output logic                         rf_we,
    output logic [$clog2(`NUM_REGS)-1:0] rf_waddr,
    output logic [`XLEN-1:0]             rf_wdata,
    output logic                         exit
);

    logic active;
    logic is_mem;
    // load accepted, waiting for rdata
    logic sent;
    logic done;

    // nothing retires once the program has ended
    assign active = xm.valid && !exit;
    assign is_mem = xm.ctrl.mem_ren || xm.ctrl.mem_wen;

    // ****************************************
    // data port
    assign d_start = active && is_mem && !sent;
    assign d_write = d_start && xm.ctrl.mem_wen;
    assign d_addr  = xm.op_a;
    assign d_wdata = xm.rs2_data;

    always_comb begin
        if (!is_mem) begin
            done = 1'b1;
        end else if (xm.ctrl.mem_wen) begin
            done = d_ready;
        end else begin
            done = sent && d_rdata_valid;
        end
    end

    assign mem_busy = active && !done;

    // ****************************************
    // writeback and redirect
    assign rf_we    = active && done && xm.ctrl.rf_wen;
    assign rf_waddr = xm.rd;

    always_comb begin
        case (xm.ctrl.wb_sel)
            core_pkg::wb_mem:      rf_wdata = d_rdata;
            core_pkg::wb_pc_plus4: rf_wdata = xm.pc + `XLEN'(4);
            default:               rf_wdata = xm.op_a;
        endcase
    end

    assign redirect    = active && br_taken;
    assign redirect_pc = br_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= 1'b0;
            exit <= 1'b0;
        end else begin
            if (d_start && d_ready && !d_write) begin
                sent <= 1'b1;
            end else if (sent && d_rdata_valid) begin
                sent <= 1'b0;
            end
            if (active && xm.ctrl.is_ecall) begin
                exit <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

// one pipeline slot between two stages
interface pipe_if;

    logic                          valid;
    logic [`XLEN-1:0]              pc;
    core_pkg::ctrl_t               ctrl;
    logic [`XLEN-1:0]              op_a;
    logic [`XLEN-1:0]              op_b;
    logic [`XLEN-1:0]              rs2_data;
    logic [`XLEN-1:0]              imm;
    logic [$clog2(`NUM_REGS)-1:0]  rd;

    modport src (output valid, pc, ctrl, op_a, op_b, rs2_data, imm, rd);

    modport snk (input valid, pc, ctrl, op_a, op_b, rs2_data, imm, rd);

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/core_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/core.sv
verif/core_chk.sv
verif/tb_core.sv

// ==== verif/core_chk.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module core_chk (
    input wire             clk,
    input wire             rst_n,
    input wire             inst_start,
    input wire             inst_ready,
    input wire [`XLEN-1:0] inst_addr,
    input wire             d_start,
    input wire             d_ready,
    input wire             d_write,
    input wire [`XLEN-1:0] d_addr,
    input wire             exit
);

    // a request stays up with a stable address until accepted
    a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_start && !inst_ready |=> inst_start && $stable(inst_addr))
        else $error("inst_start dropped or address moved before inst_ready");

    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        d_start && !d_ready |=> d_start && $stable(d_addr) && $stable(d_write))
        else $error("d_start dropped or request changed before d_ready");

    a_exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        exit |=> exit)
        else $error("exit fell while out of reset");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !inst_start)
        else $error("inst_start high during reset");

endmodule

`default_nettype wire

// ==== verif/tb_core.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module tb_core;

    localparam int NUM_ROWS = 4;
    localparam int PASSES   = 2;
    localparam int MAX_CYC  = NUM_ROWS * PASSES * 12 * 40;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic inst_ready = 1'b0;
    logic [31:0] inst_data = '0;
    logic inst_valid = 1'b0;
    logic d_ready = 1'b0;
    logic [31:0] d_rdata = '0;
    logic d_rdata_valid = 1'b0;
    wire inst_start, d_start, d_write, exit;
    wire [31:0] inst_addr, d_addr, d_wdata, gp;

    logic [31:0] prog [NUM_ROWS][12];
    logic [31:0] exp_gp [NUM_ROWS];
    logic [31:0] exp_addr [NUM_ROWS];
    logic [31:0] exp_word [NUM_ROWS];
    logic [31:0] imem [16];
    logic [31:0] dmem [64];
    logic [31:0] seed = 32'hecc5_9f82;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int i_phase = 0;
    int d_phase = 0;
    int i_wait, d_wait;
    logic [31:0] i_addr, d_raddr;

    core dut0 (.clk, .rst_n, .inst_start, .inst_addr, .inst_ready, .inst_data, .inst_valid,
        .d_start, .d_write, .d_addr, .d_wdata, .d_ready, .d_rdata, .d_rdata_valid, .exit, .gp);

    bind core core_chk chk0 (.clk, .rst_n, .inst_start, .inst_ready, .inst_addr,
        .d_start, .d_ready, .d_write, .d_addr, .exit);

    initial forever #20 clk = ~clk;

    // 0 to 3 cycles from an lcg
    function automatic int next_delay();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[17:16]);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'hd00d_0000 ^ (addr * 32'h0001_0001);
    endfunction

    // ****************************************
    // instruction encoders
    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_table();
        foreach (prog[r, k]) prog[r][k] = `INSN_ECALL;
        // dependent alu chain with lui
        prog[0][0] = addi(1, 0, 12'd5);
        prog[0][1] = addi(2, 0, 12'd7);
        prog[0][2] = r_op(7'h00, 3'b000, 3, 1, 2);
        prog[0][3] = r_op(7'h20, 3'b000, 3, 3, 1);
        prog[0][4] = lui(4, 20'h12345);
        prog[0][5] = r_op(7'h00, 3'b110, 3, 3, 4);
        prog[0][6] = r_op(7'h00, 3'b111, 5, 3, 2);
        prog[0][7] = r_op(7'h00, 3'b100, 3, 3, 5);
        exp_gp[0] = 32'h1234_5000;
        exp_addr[0] = 32'h0;
        exp_word[0] = fill_word(32'h0);
        // store then load back
        prog[1][0] = lui(1, 20'habcde);
        prog[1][1] = addi(1, 1, 12'h123);
        prog[1][2] = addi(2, 0, 12'h040);
        prog[1][3] = sw(1, 2, 12'd8);
        prog[1][4] = lw(3, 2, 12'd8);
        exp_gp[1] = 32'habcd_e123;
        exp_addr[1] = 32'h48;
        exp_word[1] = 32'habcd_e123;
        // taken beq and bne skip their shadows
        prog[2][0] = addi(3, 0, 12'd0);
        prog[2][1] = addi(1, 0, 12'd3);
        prog[2][2] = addi(2, 0, 12'd3);
        prog[2][3] = branch(3'b000, 1, 2, 13'd12);
        prog[2][4] = addi(3, 0, 12'd1);
        prog[2][5] = addi(3, 0, 12'd2);
        prog[2][6] = branch(3'b001, 1, 0, 13'd8);
        prog[2][7] = addi(3, 0, 12'd3);
        prog[2][8] = addi(3, 3, 12'h055);
        prog[2][9] = sw(3, 0, 12'd0);
        exp_gp[2] = 32'h55;
        exp_addr[2] = 32'h0;
        exp_word[2] = 32'h55;
        // jal link is pc plus 4
        prog[3][0] = addi(3, 0, 12'h010);
        prog[3][1] = jal(5, 21'd12);
        prog[3][2] = addi(3, 0, 12'hfff);
        prog[3][3] = addi(3, 0, 12'hffe);
        prog[3][4] = r_op(7'h00, 3'b000, 3, 3, 5);
        prog[3][5] = sw(5, 0, 12'd4);
        prog[3][6] = `INSN_ECALL;
        // store behind the ecall must never reach memory
        prog[3][7] = sw(3, 0, 12'd4);
        exp_gp[3] = 32'h18;
        exp_addr[3] = 32'h4;
        exp_word[3] = 32'h8;
    endtask

    // ****************************************
    // memory models
    always @(posedge clk) begin
        inst_valid <= 1'b0;
        if (!rst_n) begin
            inst_ready <= 1'b0;
            i_phase = 0;
        end else if (i_phase == 0) begin
            if (inst_start) begin
                i_wait = next_delay();
                i_phase = 1;
            end
        end else if (i_phase == 1) begin
            if (inst_ready) begin
                inst_ready <= 1'b0;
                i_addr = inst_addr;
                i_wait = next_delay();
                i_phase = 2;
            end else if (i_wait == 0) begin
                inst_ready <= 1'b1;
            end else begin
                i_wait--;
            end
        end else if (i_wait == 0) begin
            inst_valid <= 1'b1;
            inst_data <= (i_addr < 32'd64) ? imem[i_addr[5:2]] : `INSN_ECALL;
            i_phase = 0;
        end else begin
            i_wait--;
        end
    end

    always @(posedge clk) begin
        d_rdata_valid <= 1'b0;
        if (!rst_n) begin
            d_ready <= 1'b0;
            d_phase = 0;
        end else if (d_phase == 0) begin
            if (d_start) begin
                d_wait = next_delay();
                d_phase = 1;
            end
        end else if (d_phase == 1) begin
            if (d_ready) begin
                d_ready <= 1'b0;
                d_wait = next_delay();
                d_raddr = d_addr;
                d_phase = d_write ? 0 : 2;
                if (d_write) begin
                    dmem[d_addr[7:2]] = d_wdata;
                    if (exit) begin
                        errors++;
                        $display("data write seen after exit at %0t", $time);
                    end
                end
            end else if (d_wait == 0) begin
                d_ready <= 1'b1;
            end else begin
                d_wait--;
            end
        end else if (d_wait == 0) begin
            d_rdata_valid <= 1'b1;
            d_rdata <= dmem[d_raddr[7:2]];
            d_phase = 0;
        end else begin
            d_wait--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            $display("timeout: the core never raised exit after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic run_row(input int r);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        foreach (imem[k]) imem[k] = (k < 12) ? prog[r][k] : `INSN_ECALL;
        foreach (dmem[k]) dmem[k] = fill_word(32'(k * 4));
        rst_n <= 1'b1;
        @(posedge clk);
        while (!exit) @(posedge clk);
        // let stray writes show up
        repeat (6) @(posedge clk);
        checks += 3;
        if (!exit) begin
            errors++;
            $display("mismatch at %0t: row %0d exit fell after rising", $time, r);
        end
        if (gp !== exp_gp[r]) begin
            errors++;
            $display("mismatch at %0t: row %0d gp %h expected %h", $time, r, gp, exp_gp[r]);
        end
        if (dmem[exp_addr[r][7:2]] !== exp_word[r]) begin
            errors++;
            $display("mismatch at %0t: row %0d mem[%h] %h expected %h", $time, r,
                     exp_addr[r], dmem[exp_addr[r][7:2]], exp_word[r]);
        end
    endtask

    initial begin
        build_table();
        // second pass reruns with fresh latencies
        for (int p = 0; p < PASSES; p++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                run_row(r);
            end
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
